//--- tut_cfg.svh
`ifndef TUT_CFG_SVH
`define TUT_CFG_SVH

// ============================================================
// Video counter ranges
// ============================================================

// The horizontal count runs 128 to 511 and wraps back to 128
`define TUT_H_FIRST      9'd128
`define TUT_H_LAST       9'd511
// The vertical count runs 0 to 263 and steps on the horizontal wrap
`define TUT_V_LAST       9'd263

// Blanking windows, with the horizontal window inclusive at both ends
`define TUT_HBLK_LO      9'd141
`define TUT_HBLK_HI      9'd268
// Vertical blank covers rows below LO and rows at HI and above
`define TUT_VBLK_LO      9'd16
`define TUT_VBLK_HI      9'd240

// Sync pulses are active low over these inclusive ranges
`define TUT_HS_LO        9'd176
`define TUT_HS_HI        9'd207
`define TUT_VS_LO        9'd244
`define TUT_VS_HI        9'd247

// ============================================================
// Scan-out constants and CPU memory map
// ============================================================

// Pixel X is the low 8 horizontal bits minus this offset
`define TUT_PIX_OFFSET   8'd13
// Only columns below this effective X take the scroll value
`define TUT_SCROLL_COLS  8'd192

`define TUT_PAL_BASE     16'h8000
`define TUT_SCROLL_ADDR  16'h8100
`define TUT_FLIPX_ADDR   16'h8206
`define TUT_FLIPY_ADDR   16'h8207
`define TUT_OPEN_BUS     8'hFF

`endif

//--- tut_pkg.sv
package tut_pkg;

	// Plain vector types for the widths that carry a meaning
	typedef logic [8:0]  h_cnt_t;
	typedef logic [8:0]  v_cnt_t;
	typedef logic [7:0]  pix_t;
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [14:0] vram_addr_t;
	typedef logic [3:0]  pal_idx_t;
	typedef logic [4:0]  chan_t;

	// Sixteen palette bytes, entry N sits at bits N*8+7 down to N*8
	typedef byte_t [15:0] pal_file_t;

	// One CPU access as seen on the external bus
	typedef struct packed {
		logic      we;
		logic      re;
		cpu_addr_t addr;
		byte_t     wdata;
	} cpu_bus_t;

	// Screen orientation and scroll as held by the register block
	typedef struct packed {
		logic  flip_x;
		logic  flip_y;
		byte_t scroll;
	} view_t;

	// Raw counter position with its decoded blank and sync levels
	typedef struct packed {
		h_cnt_t h_cnt;
		v_cnt_t v_cnt;
		logic   blank;
		logic   hsync_n;
		logic   vsync_n;
	} beat_t;

	// Video RAM fetch request travelling from stage 1 to stage 2
	typedef struct packed {
		vram_addr_t addr;
		logic       nib_hi;
		logic       blank;
		logic       hsync_n;
		logic       vsync_n;
	} fetch_t;

	// Fetched byte plus the context stage 3 needs to finish the pixel
	typedef struct packed {
		byte_t data;
		logic  nib_hi;
		logic  blank;
		logic  hsync_n;
		logic  vsync_n;
	} pix_ctx_t;

	typedef struct packed {
		chan_t r;
		chan_t g;
		chan_t b;
	} rgb_t;

endpackage

//--- tut_video_timing.sv
`include "tut_cfg.svh"

module tut_video_timing (
	input  logic           clk_49m,
	input  logic           reset,
	output logic           cen_6m_o,
	output tut_pkg::beat_t beat_o
);
	import tut_pkg::*;

	logic [2:0] div;
	h_cnt_t     h_next;
	v_cnt_t     v_next;
	logic       hblk_next;
	logic       vblk_next;

	// Free running divide by eight of the 49.152 MHz clock
	// Reset clears it so the first enable lands right after release
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			div <= 3'd0;
		end else begin
			div <= div + 3'd1;
		end
	end

	assign cen_6m_o = (div == 3'd0);

	// Next counter position, the vertical count steps on the line wrap
	always_comb begin
		h_next = beat_o.h_cnt + 9'd1;
		v_next = beat_o.v_cnt;
		if (beat_o.h_cnt == `TUT_H_LAST) begin
			h_next = `TUT_H_FIRST;
			if (beat_o.v_cnt == `TUT_V_LAST) begin
				v_next = '0;
			end else begin
				v_next = beat_o.v_cnt + 9'd1;
			end
		end
	end

	// Blank windows decoded from the next position
	assign hblk_next = (h_next >= `TUT_HBLK_LO) && (h_next <= `TUT_HBLK_HI);
	assign vblk_next = (v_next < `TUT_VBLK_LO) || (v_next >= `TUT_VBLK_HI);

	// The flags are loaded together with the counters they describe,
	// so every beat carries a count and its own decoded levels
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			beat_o.h_cnt   <= `TUT_H_FIRST;
			beat_o.v_cnt   <= '0;
			// Row 0 lies in vertical blank
			beat_o.blank   <= 1'b1;
			beat_o.hsync_n <= 1'b1;
			beat_o.vsync_n <= 1'b1;
		end else if (cen_6m_o) begin
			beat_o.h_cnt   <= h_next;
			beat_o.v_cnt   <= v_next;
			beat_o.blank   <= hblk_next | vblk_next;
			beat_o.hsync_n <= !((h_next >= `TUT_HS_LO) && (h_next <= `TUT_HS_HI));
			beat_o.vsync_n <= !((v_next >= `TUT_VS_LO) && (v_next <= `TUT_VS_HI));
		end
	end

endmodule

//--- tut_bus_regs.sv
`include "tut_cfg.svh"

module tut_bus_regs (
	input  logic                clk_49m,
	input  logic                reset,
	input  tut_pkg::cpu_bus_t   bus_i,
	input  tut_pkg::byte_t      vram_q_i,
	output logic                vram_we_o,
	output tut_pkg::vram_addr_t vram_addr_o,
	output tut_pkg::byte_t      vram_wdata_o,
	output tut_pkg::view_t      view_o,
	output tut_pkg::pal_file_t  pal_o,
	output tut_pkg::byte_t      rdata_o
);
	import tut_pkg::*;

	logic  hit_vram;
	logic  hit_pal;
	logic  hit_scroll;
	logic  rd_vram;
	byte_t rd_byte;

	// ============================================================
	// Address decode
	// ============================================================

	// Video RAM fills the lower half of the map
	assign hit_vram   = !bus_i.addr[15];
	assign hit_pal    = (bus_i.addr[15:4] == `TUT_PAL_BASE >> 4);
	assign hit_scroll = (bus_i.addr == `TUT_SCROLL_ADDR);

	// Port A of the video RAM follows the bus directly
	assign vram_we_o    = bus_i.we && hit_vram;
	assign vram_addr_o  = bus_i.addr[14:0];
	assign vram_wdata_o = bus_i.wdata;

	// Palette, scroll and the two flip bits of the main latch
	// Writes land at the edge of the strobe clock, independent of the pixel enable
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			pal_o  <= '0;
			view_o <= '0;
		end else if (bus_i.we) begin
			if (hit_pal) begin
				pal_o[bus_i.addr[3:0]] <= bus_i.wdata;
			end
			if (hit_scroll) begin
				view_o.scroll <= bus_i.wdata;
			end
			// Latch bits take data bit 0 only
			if (bus_i.addr == `TUT_FLIPX_ADDR) begin
				view_o.flip_x <= bus_i.wdata[0];
			end
			if (bus_i.addr == `TUT_FLIPY_ADDR) begin
				view_o.flip_y <= bus_i.wdata[0];
			end
		end
	end

	// ============================================================
	// Read-back
	// ============================================================

	// A read remembers whether it hit video RAM, whose byte arrives a
	// clock later from port A, or else captures the register byte now
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			rd_vram <= 1'b0;
			rd_byte <= `TUT_OPEN_BUS;
		end else if (bus_i.re) begin
			rd_vram <= hit_vram;
			if (hit_pal) begin
				rd_byte <= pal_o[bus_i.addr[3:0]];
			end else if (hit_scroll) begin
				rd_byte <= view_o.scroll;
			end else begin
				rd_byte <= `TUT_OPEN_BUS;
			end
		end
	end

	assign rdata_o = rd_vram ? vram_q_i : rd_byte;

endmodule

//--- tut_scan_addr.sv
`include "tut_cfg.svh"

module tut_scan_addr (
	input  logic            clk_49m,
	input  logic            reset,
	input  logic            cen_6m_i,
	input  tut_pkg::beat_t  beat_i,
	input  tut_pkg::view_t  view_i,
	output tut_pkg::fetch_t fetch_o
);
	import tut_pkg::*;

	pix_t pix_x;
	pix_t eff_x;
	pix_t row;
	pix_t eff_y;
	byte_t scroll_add;

	// Pixel 0 sits at horizontal count 269, whose low byte is 13
	assign pix_x = beat_i.h_cnt[7:0] - `TUT_PIX_OFFSET;
	assign eff_x = pix_x ^ {8{view_i.flip_x}};
	assign row   = beat_i.v_cnt[7:0] ^ {8{view_i.flip_y}};

	// Scroll moves the row only in the columns below the limit
	// The right hand strip stays fixed on screen
	assign scroll_add = (eff_x < `TUT_SCROLL_COLS) ? view_i.scroll : 8'd0;
	// Wraps modulo 256 within the 256 row bitmap
	assign eff_y = row + scroll_add;

	// Two pixels share a byte, so X bit 0 picks the nibble
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			fetch_o.addr    <= '0;
			fetch_o.nib_hi  <= 1'b0;
			fetch_o.blank   <= 1'b1;
			fetch_o.hsync_n <= 1'b1;
			fetch_o.vsync_n <= 1'b1;
		end else if (cen_6m_i) begin
			fetch_o.addr    <= {eff_y, eff_x[7:1]};
			fetch_o.nib_hi  <= eff_x[0];
			fetch_o.blank   <= beat_i.blank;
			fetch_o.hsync_n <= beat_i.hsync_n;
			fetch_o.vsync_n <= beat_i.vsync_n;
		end
	end

endmodule

//--- tut_vram.sv
module tut_vram (
	input  logic                clk_49m,
	input  logic                cen_6m_i,
	input  logic                cpu_we_i,
	input  tut_pkg::vram_addr_t cpu_addr_i,
	input  tut_pkg::byte_t      cpu_wdata_i,
	output tut_pkg::byte_t      cpu_q_o,
	input  tut_pkg::fetch_t     fetch_i,
	output tut_pkg::pix_ctx_t   ctx_o
);
	import tut_pkg::*;

	// 32K x 8 bitmap, two 4-bit pixels per byte
	byte_t mem [0:32767];

	// Port A serves the CPU on every clock
	// The read returns the old byte when a write hits the same address
	always_ff @(posedge clk_49m) begin
		if (cpu_we_i) begin
			mem[cpu_addr_i] <= cpu_wdata_i;
		end
		cpu_q_o <= mem[cpu_addr_i];
	end

	// Port B is read only and steps with the pixel enable
	// The fetch context rides along so stage 3 sees it with the byte
	always_ff @(posedge clk_49m) begin
		if (cen_6m_i) begin
			ctx_o.data    <= mem[fetch_i.addr];
			ctx_o.nib_hi  <= fetch_i.nib_hi;
			ctx_o.blank   <= fetch_i.blank;
			ctx_o.hsync_n <= fetch_i.hsync_n;
			ctx_o.vsync_n <= fetch_i.vsync_n;
		end
	end

endmodule

//--- tut_pixel_out.sv
module tut_pixel_out (
	input  logic               clk_49m,
	input  logic               reset,
	input  logic               cen_6m_i,
	input  tut_pkg::pix_ctx_t  ctx_i,
	input  tut_pkg::pal_file_t pal_i,
	output tut_pkg::rgb_t      rgb_o,
	output logic               hsync_n_o,
	output logic               vsync_n_o,
	output logic               blank_o
);
	import tut_pkg::*;

	pal_idx_t pix_idx;
	byte_t    pal_byte;
	rgb_t     rgb_next;

	// Upper nibble for odd pixels, lower nibble for even ones
	assign pix_idx  = ctx_i.nib_hi ? ctx_i.data[7:4] : ctx_i.data[3:0];
	assign pal_byte = pal_i[pix_idx];

	// Palette byte is BBGGGRRR
	// Each channel is widened to 5 bits by repeating its top bits
	assign rgb_next.r = {pal_byte[2:0], pal_byte[2:1]};
	assign rgb_next.g = {pal_byte[5:3], pal_byte[5:4]};
	assign rgb_next.b = {pal_byte[7:6], pal_byte[7:6], pal_byte[7]};

	// Output register, blank forces black so no stray colour leaks
	// into the borders
	always_ff @(posedge clk_49m) begin
		if (!reset) begin
			rgb_o     <= '0;
			hsync_n_o <= 1'b1;
			vsync_n_o <= 1'b1;
			blank_o   <= 1'b1;
		end else if (cen_6m_i) begin
			rgb_o     <= ctx_i.blank ? '0 : rgb_next;
			hsync_n_o <= ctx_i.hsync_n;
			vsync_n_o <= ctx_i.vsync_n;
			blank_o   <= ctx_i.blank;
		end
	end

endmodule

//--- tut_video_top.sv
module tut_video_top (
	input  logic              clk_49m,
	input  logic              reset,
	input  tut_pkg::cpu_bus_t bus_i,
	output tut_pkg::byte_t    rdata_o,
	output tut_pkg::rgb_t     rgb_o,
	output logic              hsync_n_o,
	output logic              vsync_n_o,
	output logic              blank_o,
	output logic              ce_pix_o
);
	import tut_pkg::*;

	logic       cen_6m;
	beat_t      beat;
	fetch_t     fetch;
	pix_ctx_t   ctx;
	view_t      view;
	pal_file_t  pal;
	logic       vram_we;
	vram_addr_t vram_addr;
	byte_t      vram_wdata;
	byte_t      vram_q;

	// ============================================================
	// Timing and CPU side
	// ============================================================

	tut_video_timing u_timing (
		.clk_49m  (clk_49m),
		.reset    (reset),
		.cen_6m_o (cen_6m),
		.beat_o   (beat)
	);

	// Outputs at an enable belong to the beat three enables back
	assign ce_pix_o = cen_6m;

	tut_bus_regs u_bus_regs (
		.clk_49m      (clk_49m),
		.reset        (reset),
		.bus_i        (bus_i),
		.vram_q_i     (vram_q),
		.vram_we_o    (vram_we),
		.vram_addr_o  (vram_addr),
		.vram_wdata_o (vram_wdata),
		.view_o       (view),
		.pal_o        (pal),
		.rdata_o      (rdata_o)
	);

	// ============================================================
	// Scan-out pipeline, one stage per enable
	// ============================================================

	tut_scan_addr u_scan_addr (
		.clk_49m  (clk_49m),
		.reset    (reset),
		.cen_6m_i (cen_6m),
		.beat_i   (beat),
		.view_i   (view),
		.fetch_o  (fetch)
	);

	tut_vram u_vram (
		.clk_49m     (clk_49m),
		.cen_6m_i    (cen_6m),
		.cpu_we_i    (vram_we),
		.cpu_addr_i  (vram_addr),
		.cpu_wdata_i (vram_wdata),
		.cpu_q_o     (vram_q),
		.fetch_i     (fetch),
		.ctx_o       (ctx)
	);

	tut_pixel_out u_pixel_out (
		.clk_49m   (clk_49m),
		.reset     (reset),
		.cen_6m_i  (cen_6m),
		.ctx_i     (ctx),
		.pal_i     (pal),
		.rgb_o     (rgb_o),
		.hsync_n_o (hsync_n_o),
		.vsync_n_o (vsync_n_o),
		.blank_o   (blank_o)
	);

endmodule

//--- tb_tut_video.sv
module tb_tut_video;
	timeunit 1ns;
	timeprecision 100ps;
	import tut_pkg::*;

	// ============================================================
	// Video timing rules and run length
	// ============================================================

	localparam int H_FIRST = 128;
	localparam int H_LAST  = 511;
	localparam int V_LAST  = 263;
	localparam int HBLK_LO = 141;
	localparam int HBLK_HI = 268;
	localparam int VBLK_LO = 16;
	localparam int VBLK_HI = 240;
	localparam int HS_LO   = 176;
	localparam int HS_HI   = 207;
	localparam int VS_LO   = 244;
	localparam int VS_HI   = 247;
	// Bitmap rows that get random contents
	localparam int FILL_ROW  = 80;
	localparam int FILL_ROWS = 64;
	localparam int READS     = 64;
	// A frame is 384 beats by 264 lines, eight clocks per beat
	localparam longint FRAME_EN   = 384 * 264;
	localparam longint FRAME_CLKS = FRAME_EN * 8;
	// Tests 2 to 4 run six frames, every bus access costs one clock
	localparam longint BUS_OPS  = FILL_ROWS * 128 + 16 + 3 + 4 * 3 + READS + 2;
	localparam longint LIMIT_NS = (7 * FRAME_CLKS + 2 * BUS_OPS + 20) * 10;

	logic     clk_49m;
	logic     reset;
	cpu_bus_t bus;
	byte_t    rdata;
	rgb_t     rgb;
	logic     hsync_n;
	logic     vsync_n;
	logic     blank;
	logic     ce_pix;

	// Reference model state, updated at every write the testbench issues
	logic [31:0] lfsr;
	logic [7:0]  m_mem [0:32767];
	bit          m_ok [0:32767];
	logic [7:0]  m_pal [0:15];
	logic [7:0]  m_scroll;
	logic        m_fx;
	logic        m_fy;
	int          m_h;
	int          m_v;
	// Beats in flight, three enables deep, reset entries hold -1
	int          q_h [$];
	int          q_v [$];
	bit          mon_on;
	bit          rgb_chk;
	int          since_wr;
	longint      enables;
	int          en_gap;
	int          n_scrolled;
	int          n_fixed;
	int          t_checks;
	int          t_errs;
	int          checks;
	int          errors;

	tut_video_top uut (
		.clk_49m   (clk_49m),
		.reset     (reset),
		.bus_i     (bus),
		.rdata_o   (rdata),
		.rgb_o     (rgb),
		.hsync_n_o (hsync_n),
		.vsync_n_o (vsync_n),
		.blank_o   (blank),
		.ce_pix_o  (ce_pix)
	);

	always #5 clk_49m = ~clk_49m;

	// ============================================================
	// Helpers
	// ============================================================

	// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		int          i;
		val = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	task automatic compare_val(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		t_checks++;
		if (got !== exp) begin
			errors++;
			t_errs++;
			$display("CHECK FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, exp, got);
		end
	endtask

	task automatic report_fail(input string msg);
		errors++;
		t_errs++;
		$display("%s", msg);
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d mismatches", name, t_checks, t_errs);
		t_checks = 0;
		t_errs = 0;
	endtask

	// Counter rules, the vertical count steps when the line wraps
	task automatic step_counters();
		if (m_h == H_LAST) begin
			m_h = H_FIRST;
			m_v = (m_v == V_LAST) ? 0 : m_v + 1;
		end else begin
			m_h = m_h + 1;
		end
	endtask

	// Memory map as seen by the CPU
	task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
		if (!addr[15]) begin
			m_mem[addr[14:0]] = data;
			m_ok[addr[14:0]] = 1'b1;
		end else if (addr[15:4] == 12'h800) begin
			m_pal[addr[3:0]] = data;
		end else if (addr == 16'h8100) begin
			m_scroll = data;
		end else if (addr == 16'h8206) begin
			m_fx = data[0];
		end else if (addr == 16'h8207) begin
			m_fy = data[0];
		end
	endtask

	function automatic logic [7:0] model_read(input logic [15:0] addr);
		if (!addr[15]) begin
			return m_mem[addr[14:0]];
		end
		if (addr[15:4] == 12'h800) begin
			return m_pal[addr[3:0]];
		end
		if (addr == 16'h8100) begin
			return m_scroll;
		end
		// Everything else floats to open bus
		return 8'hFF;
	endfunction

	// Expected colour of one beat: flip, column-limited scroll, nibble, palette
	task automatic model_pixel(input int h, input int v, output logic [14:0] exp_rgb,
			output bit known, output bit scrolled);
		logic [7:0]  px;
		logic [7:0]  ex;
		logic [7:0]  row;
		logic [7:0]  ey;
		logic [14:0] addr;
		logic [7:0]  data;
		logic [3:0]  idx;
		logic [7:0]  p;
		px = h[7:0] - 8'd13;
		ex = m_fx ? ~px : px;
		row = m_fy ? ~v[7:0] : v[7:0];
		scrolled = (ex < 8'd192);
		ey = scrolled ? row + m_scroll : row;
		addr = {ey, ex[7:1]};
		known = m_ok[addr];
		data = m_mem[addr];
		idx = ex[0] ? data[7:4] : data[3:0];
		p = m_pal[idx];
		// BBGGGRRR widened by repeating the top bits of each field
		exp_rgb = {p[2:0], p[2:1], p[5:3], p[5:4], p[7:6], p[7:6], p[7]};
	endtask

	// Checks the outputs of the current cycle when it carries an enable
	task automatic sample_cycle();
		int          eh;
		int          ev;
		bit          exp_blank;
		bit          exp_hs;
		bit          exp_vs;
		logic [14:0] exp_rgb;
		bit          known;
		bit          scrolled;
		// Enables come exactly eight clocks apart
		if (mon_on) begin
			en_gap++;
			if (ce_pix) begin
				if (enables > 0) begin
					compare_val("ce_pix_o period", 16'(en_gap), 16'd8);
				end
				en_gap = 0;
			end
		end
		if (mon_on && ce_pix) begin
			q_h.push_back(m_h);
			q_v.push_back(m_v);
			step_counters();
			eh = q_h.pop_front();
			ev = q_v.pop_front();
			if (since_wr < 1000) begin
				since_wr++;
			end
			enables++;
			if (eh < 0) begin
				exp_blank = 1'b1;
				exp_hs = 1'b1;
				exp_vs = 1'b1;
			end else begin
				exp_blank = (eh >= HBLK_LO && eh <= HBLK_HI) || ev < VBLK_LO || ev >= VBLK_HI;
				exp_hs = !(eh >= HS_LO && eh <= HS_HI);
				exp_vs = !(ev >= VS_LO && ev <= VS_HI);
			end
			compare_val("blank_o", 16'(blank), 16'(exp_blank));
			compare_val("hsync_n_o", 16'(hsync_n), 16'(exp_hs));
			compare_val("vsync_n_o", 16'(vsync_n), 16'(exp_vs));
			if (exp_blank) begin
				compare_val("rgb_o", 16'(rgb), 16'd0);
			end else if (rgb_chk && since_wr >= 4) begin
				// A write needs four enables to reach every stage
				model_pixel(eh, ev, exp_rgb, known, scrolled);
				if (known) begin
					compare_val("rgb_o", 16'(rgb), 16'(exp_rgb));
					if (scrolled) begin
						n_scrolled++;
					end else begin
						n_fixed++;
					end
				end
			end
		end
	endtask

	task automatic tick();
		@(posedge clk_49m);
		#1;
		sample_cycle();
	endtask

	task automatic run_enables(input longint n);
		longint target;
		target = enables + n;
		while (enables < target) begin
			tick();
		end
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		bus.we = 1'b1;
		bus.re = 1'b0;
		bus.addr = addr;
		bus.wdata = data;
		since_wr = 0;
		model_write(addr, data);
		tick();
		bus = '0;
	endtask

	// Read data is valid one clock after the strobe
	task automatic bus_read(input logic [15:0] addr);
		logic [7:0] exp;
		exp = model_read(addr);
		bus.we = 1'b0;
		bus.re = 1'b1;
		bus.addr = addr;
		bus.wdata = '0;
		tick();
		bus = '0;
		compare_val("rdata_o", 16'(rdata), 16'(exp));
	endtask

	// ============================================================
	// Tests
	// ============================================================

	initial begin
		int          i;
		int          r;
		int          combo;
		logic [15:0] addr;
		clk_49m = 1'b0;
		reset = 1'b0;
		bus = '0;
		lfsr = 32'he87aa9f0;
		for (i = 0; i < 16; i++) begin
			m_pal[i] = 8'd0;
		end
		m_scroll = 8'd0;
		m_fx = 1'b0;
		m_fy = 1'b0;
		m_h = H_FIRST;
		m_v = 0;
		// The three stages still hold their reset contents
		for (i = 0; i < 3; i++) begin
			q_h.push_back(-1);
			q_v.push_back(-1);
		end
		mon_on = 1'b0;
		rgb_chk = 1'b0;
		since_wr = 1000;
		enables = 0;
		en_gap = 0;
		checks = 0;
		errors = 0;
		t_checks = 0;
		t_errs = 0;
		repeat (10) @(posedge clk_49m);
		#1;
		reset = 1'b1;
		mon_on = 1'b1;
		// The cycle right after release carries the first enable
		sample_cycle();
		compare_val("ce_pix_o", 16'(ce_pix), 16'd1);
		compare_val("rgb_o", 16'(rgb), 16'd0);
		compare_val("hsync_n_o", 16'(hsync_n), 16'd1);
		compare_val("vsync_n_o", 16'(vsync_n), 16'd1);
		compare_val("rdata_o", 16'(rdata), 16'hFF);
		bus_read(16'h8000 | 16'(rand_bits(4)));
		end_test("1 reset state");

		run_enables(FRAME_EN);
		end_test("2 sync and blank over one frame");

		for (r = 0; r < FILL_ROWS; r++) begin
			for (i = 0; i < 128; i++) begin
				bus_write(16'((FILL_ROW + r) * 128 + i), 8'(rand_bits(8)));
			end
		end
		for (i = 0; i < 16; i++) begin
			bus_write(16'h8000 + 16'(i), 8'(rand_bits(8)));
		end
		bus_write(16'h8100, 8'd0);
		bus_write(16'h8206, 8'd0);
		bus_write(16'h8207, 8'd0);
		n_scrolled = 0;
		n_fixed = 0;
		rgb_chk = 1'b1;
		run_enables(FRAME_EN);
		if (n_scrolled + n_fixed == 0) begin
			report_fail("No visible pixel of the filled rows was compared");
		end
		end_test("3 rgb without flip or scroll");

		for (combo = 0; combo < 4; combo++) begin
			// Upper data bits are random, the latch keeps bit 0 only
			bus_write(16'h8206, {7'(rand_bits(7)), combo[0]});
			bus_write(16'h8207, {7'(rand_bits(7)), combo[1]});
			bus_write(16'h8100, 8'(rand_bits(8)));
			n_scrolled = 0;
			n_fixed = 0;
			run_enables(FRAME_EN);
			if (n_scrolled == 0 || n_fixed == 0) begin
				report_fail("Scrolled or fixed columns were never compared in this pass");
			end
			end_test($sformatf("4.%0d rgb with flip x %0d, flip y %0d, scroll 0x%02h",
				combo, m_fx, m_fy, m_scroll));
		end
		rgb_chk = 1'b0;

		for (i = 0; i < READS; i++) begin
			case (rand_bits(2))
				0: begin
					r = int'(rand_bits(6));
					addr = 16'((FILL_ROW + r) * 128 + int'(rand_bits(7)));
				end
				1: addr = 16'h8000 | 16'(rand_bits(4));
				2: addr = 16'h8100;
				default: begin
					addr = 16'h8000 | 16'(rand_bits(15));
					while (addr[15:4] == 12'h800 || addr == 16'h8100) begin
						addr = 16'h8000 | 16'(rand_bits(15));
					end
				end
			endcase
			bus_read(addr);
		end
		end_test("5 bus read-back");

		$display("checks %0d, failures %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Watchdog sized from six frames of enables plus the bus traffic
	initial begin
		#(LIMIT_NS);
		$display("Timeout: the tests did not finish within %0d ns", LIMIT_NS);
		$display("Errors found");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+.
tut_pkg.sv
tut_video_timing.sv
tut_bus_regs.sv
tut_scan_addr.sv
tut_vram.sv
tut_pixel_out.sv
tut_video_top.sv
tb_tut_video.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_tut_video -o sim_tut_video
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tut_video > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Errors found" sim.log; then
	echo "simulation reported failures"
	exit 1
fi

echo "simulation passed"
exit 0
